// File: ControlUnit.sv
// Main control decoder for the decode stage.
// Turns the 7-bit major opcode into the control set carried down the
// pipeline. Purely combinational; unknown opcodes give all zeros and
// raise Illegal.

module ControlUnit (
    input  logic [DecodePkg::OpcodeWidth-1:0] opcode,
    output logic                              ALUSrc,    // Immediate as ALU operand B
    output logic [1:0]                        ALUOp,     // To execute ALU control
    output logic                              Branch,    // Conditional branch
    output logic                              Jump,      // JAL or JALR
    output logic                              MemRead,   // Load in memory stage
    output logic                              MemWrite,  // Store in memory stage
    output logic                              MemtoReg,  // Writeback takes load data
    output logic                              RegWrite,  // Writeback enable
    output logic                              Illegal    // Opcode not in RV32I
);

    import DecodePkg::*;

    always_comb begin
        // Defaults describe a no-op
        ALUSrc   = 1'b0;
        ALUOp    = AluOpAdd;
        Branch   = 1'b0;
        Jump     = 1'b0;
        MemRead  = 1'b0;
        MemWrite = 1'b0;
        MemtoReg = 1'b0;
        RegWrite = 1'b0;
        Illegal  = 1'b0;
        case (opcode)
            OpLui, OpAuipc: begin
                ALUSrc   = 1'b1;  // Upper immediate
                RegWrite = 1'b1;
            end
            OpJal, OpJalr: begin
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;  // Link register
                Jump     = 1'b1;
            end
            OpBranch: begin
                ALUOp    = AluOpBranch;
                Branch   = 1'b1;
            end
            OpLoad: begin
                ALUSrc   = 1'b1;  // Base plus offset
                MemRead  = 1'b1;
                MemtoReg = 1'b1;
                RegWrite = 1'b1;
            end
            OpStore: begin
                ALUSrc   = 1'b1;
                MemWrite = 1'b1;
            end
            OpImm: begin
                ALUOp    = AluOpFunct;
                ALUSrc   = 1'b1;
                RegWrite = 1'b1;
            end
            OpReg: begin
                ALUOp    = AluOpFunct;
                RegWrite = 1'b1;
            end
            OpFence, OpSystem: begin
                // No ordering or CSR support, pass through as bubble-like no-op
            end
            default: begin
                Illegal  = 1'b1;
            end
        endcase
    end

    // A load and a store are never decoded from one opcode
    always_comb begin
        assert #0 (!(MemRead && MemWrite))
            else $error("ControlUnit: MemRead and MemWrite both set");
    end

endmodule

// File: DecodePkg.sv
// Shared constants for the RV32I instruction decode stage.
// Holds the data and field widths, the major opcode values and the
// ALUOp encoding passed from decode to execute.
// Modules import it inside their body and use scoped names in port lists.

package DecodePkg;

    // Widths
    localparam int Xlen         = 32;  // Data and address width
    localparam int OpcodeWidth  = 7;   // Major opcode field instr[6:0]
    localparam int RegAddrWidth = 5;   // rs1, rs2 and rd fields

    // Major opcodes, RV32I base set
    localparam logic [OpcodeWidth-1:0] OpLui    = 7'b0110111;
    localparam logic [OpcodeWidth-1:0] OpAuipc  = 7'b0010111;
    localparam logic [OpcodeWidth-1:0] OpJal    = 7'b1101111;
    localparam logic [OpcodeWidth-1:0] OpJalr   = 7'b1100111;
    localparam logic [OpcodeWidth-1:0] OpBranch = 7'b1100011;
    localparam logic [OpcodeWidth-1:0] OpLoad   = 7'b0000011;
    localparam logic [OpcodeWidth-1:0] OpStore  = 7'b0100011;
    localparam logic [OpcodeWidth-1:0] OpImm    = 7'b0010011;  // Register-immediate ALU
    localparam logic [OpcodeWidth-1:0] OpReg    = 7'b0110011;  // Register-register ALU
    localparam logic [OpcodeWidth-1:0] OpFence  = 7'b0001111;  // Decoded as no-op
    localparam logic [OpcodeWidth-1:0] OpSystem = 7'b1110011;  // Decoded as no-op

    // ALUOp field, refined by funct3/funct7 in execute
    localparam logic [1:0] AluOpAdd    = 2'b00;  // Address or plain add
    localparam logic [1:0] AluOpBranch = 2'b01;  // Compare for branch
    localparam logic [1:0] AluOpFunct  = 2'b10;  // Use funct fields

endpackage

// File: DecodeStage.f
DecodePkg.sv
ControlUnit.sv
ImmGen.sv
RegFile.sv
DecodeStage.sv
DecodeStageTb.sv

// File: DecodeStage.sv
// Instruction decode stage of a five-stage RV32I pipeline.
// Decodes one fetched instruction, builds its immediate, reads rs1/rs2
// and captures everything in the ID/EX register for execute.
// stall holds the register, flush or instrValid low loads a bubble.

module DecodeStage #(
    parameter int NumRegs = 32
) (
    input  logic                               clk,
    input  logic                               reset_n,
    // From fetch
    input  logic                               instrValid,
    input  logic [DecodePkg::Xlen-1:0]         instr,
    input  logic [DecodePkg::Xlen-1:0]         pc,
    // From hazard logic
    input  logic                               stall,
    input  logic                               flush,
    // From writeback
    input  logic                               wbEnable,
    input  logic [DecodePkg::RegAddrWidth-1:0] wbAddr,
    input  logic [DecodePkg::Xlen-1:0]         wbData,
    // ID/EX register
    output logic                               exValid,
    output logic [DecodePkg::Xlen-1:0]         exPc,
    output logic [DecodePkg::Xlen-1:0]         exRs1Data,
    output logic [DecodePkg::Xlen-1:0]         exRs2Data,
    output logic [DecodePkg::Xlen-1:0]         exImm,
    output logic [DecodePkg::RegAddrWidth-1:0] exRd,
    output logic [2:0]                         exFunct3,
    output logic                               exFunct7b5,
    output logic                               exALUSrc,
    output logic [1:0]                         exALUOp,
    output logic                               exBranch,
    output logic                               exJump,
    output logic                               exMemRead,
    output logic                               exMemWrite,
    output logic                               exMemtoReg,
    output logic                               exRegWrite,
    output logic                               exIllegal
);

    import DecodePkg::*;

    logic [OpcodeWidth-1:0]  opcode;
    logic [RegAddrWidth-1:0] rd;
    logic [RegAddrWidth-1:0] rs1;
    logic [RegAddrWidth-1:0] rs2;
    logic [Xlen-1:0]         imm;
    logic [Xlen-1:0]         rs1Data;
    logic [Xlen-1:0]         rs2Data;
    logic                    aluSrc;
    logic [1:0]              aluOp;
    logic                    branch;
    logic                    jump;
    logic                    memRead;
    logic                    memWrite;
    logic                    memtoReg;
    logic                    regWrite;
    logic                    opIllegal;
    logic                    usesRs1;
    logic                    usesRs2;
    logic                    badReg;
    logic                    bubble;

    assign opcode = instr[OpcodeWidth-1:0];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    ControlUnit ctrl (
        .opcode  (opcode),
        .ALUSrc  (aluSrc),
        .ALUOp   (aluOp),
        .Branch  (branch),
        .Jump    (jump),
        .MemRead (memRead),
        .MemWrite(memWrite),
        .MemtoReg(memtoReg),
        .RegWrite(regWrite),
        .Illegal (opIllegal)
    );

    ImmGen immGen (
        .instr(instr),
        .imm  (imm)
    );

    RegFile #(.NumRegs(NumRegs)) regFile (
        .clk     (clk),
        .reset_n (reset_n),
        .rs1Addr (rs1),
        .rs2Addr (rs2),
        .wrAddr  (wbAddr),
        .wrEnable(wbEnable),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // Register fields each format really reads
    assign usesRs1 = opcode inside {OpReg, OpImm, OpLoad, OpStore, OpBranch, OpJalr};
    assign usesRs2 = opcode inside {OpReg, OpStore, OpBranch};

    // Register numbers past NumRegs are illegal (RV32E)
    assign badReg = (regWrite && 32'(rd) >= NumRegs)
                  || (usesRs1 && 32'(rs1) >= NumRegs)
                  || (usesRs2 && 32'(rs2) >= NumRegs);

    assign bubble = flush || !instrValid;

    // Control half, cleared on reset and bubble; flush wins over stall
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exValid    <= 1'b0;
            exALUSrc   <= 1'b0;
            exALUOp    <= AluOpAdd;
            exBranch   <= 1'b0;
            exJump     <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exMemtoReg <= 1'b0;
            exRegWrite <= 1'b0;
            exIllegal  <= 1'b0;
        end else if (flush || !stall) begin
            exValid    <= !bubble;
            exALUSrc   <= !bubble && aluSrc;
            exALUOp    <= bubble ? AluOpAdd : aluOp;
            exBranch   <= !bubble && branch;
            exJump     <= !bubble && jump;
            exMemRead  <= !bubble && memRead;
            exMemWrite <= !bubble && memWrite;
            exMemtoReg <= !bubble && memtoReg;
            exRegWrite <= !bubble && regWrite;
            exIllegal  <= !bubble && (opIllegal || badReg);
        end
    end

    // Payload half, meaningless in a bubble
    always_ff @(posedge clk) begin
        if (!stall) begin
            exPc       <= pc;
            exRs1Data  <= rs1Data;
            exRs2Data  <= rs2Data;
            exImm      <= imm;
            exRd       <= rd;
            exFunct3   <= instr[14:12];
            exFunct7b5 <= instr[30];
        end
    end

    // Flush always empties execute on the next cycle, stall or not
    assert property (@(posedge clk) disable iff (!reset_n) flush |=> !exValid);

    assert property (@(posedge clk) disable iff (!reset_n)
        exValid |-> !(exMemRead && exMemWrite));

endmodule

// File: DecodeStageTb.sv
// Self-checking testbench for the RV32I decode stage.
// Applies a table of instructions, writeback traffic, stalls and flushes
// one entry per cycle. The ID/EX outputs are checked against a reference
// model that keeps its own copy of the register file.

module DecodeStageTb;

    import DecodePkg::*;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 5;
    localparam int NumRegs     = 32;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        instrValid;
        logic        stall;
        logic        flush;
        logic        wbEnable;
        logic [4:0]  wbAddr;
        logic [31:0] wbData;
    } StimEntry;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    logic        wbEnable;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        exValid;
    logic [31:0] exPc;
    logic [31:0] exRs1Data;
    logic [31:0] exRs2Data;
    logic [31:0] exImm;
    logic [4:0]  exRd;
    logic [2:0]  exFunct3;
    logic        exFunct7b5;
    logic        exALUSrc;
    logic [1:0]  exALUOp;
    logic        exBranch;
    logic        exJump;
    logic        exMemRead;
    logic        exMemWrite;
    logic        exMemtoReg;
    logic        exRegWrite;
    logic        exIllegal;

    StimEntry    stimTable[$];
    logic [31:0] lfsrState;
    logic [31:0] pcNext;              // PC given to the next table entry
    logic [31:0] shadow [NumRegs];    // Model copy of the register file
    logic        expValid;
    logic [9:0]  expCtrl;             // Same bit order as controlFor
    logic [31:0] expPc;
    logic [31:0] expRs1;
    logic [31:0] expRs2;
    logic [31:0] expImm;
    logic [4:0]  expRd;
    logic [2:0]  expFunct3;
    logic        expFunct7b5;

    DecodeStage #(.NumRegs(NumRegs)) dut (.*);  // TB signals carry port names

    always #(ClkPeriod / 2) clk = ~clk;

    // Galois LFSR, x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'hD000_0001) : (state >> 1);
    endfunction

    task automatic nextRandom(output logic [31:0] value);
        value = '0;
        for (int i = 0; i < 32; i++) begin
            value     = {value[30:0], lfsrState[0]};  // One bit per step
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    task automatic addEntry(input logic [31:0] word, input logic valid, input logic stallIn,
                            input logic flushIn, input logic wbEn, input logic [4:0] wbA,
                            input logic [31:0] wbD);
        StimEntry e;
        e = '{word, pcNext, valid, stallIn, flushIn, wbEn, wbA, wbD};
        stimTable.push_back(e);
        pcNext = pcNext + 32'd4;
    endtask

    // {ALUSrc, ALUOp, Branch, Jump, MemRead, MemWrite, MemtoReg, RegWrite, Illegal}
    function automatic logic [9:0] controlFor(input logic [6:0] op);
        case (op)
            OpLui, OpAuipc:    return 10'b1_00_0_0_0_0_0_1_0;
            OpJal, OpJalr:     return 10'b1_00_0_1_0_0_0_1_0;
            OpBranch:          return 10'b0_01_1_0_0_0_0_0_0;
            OpLoad:            return 10'b1_00_0_0_1_0_1_1_0;
            OpStore:           return 10'b1_00_0_0_0_1_0_0_0;
            OpImm:             return 10'b1_10_0_0_0_0_0_1_0;
            OpReg:             return 10'b0_10_0_0_0_0_0_1_0;
            OpFence, OpSystem: return 10'b0;  // No-ops
            default:           return 10'b0_00_0_0_0_0_0_0_1;
        endcase
    endfunction

    // Field packed at the top, arithmetic shift brings the sign down
    function automatic logic [31:0] immFor(input logic [31:0] ins);
        logic signed [31:0] top;
        top = '0;
        case (ins[6:0])
            OpLoad, OpImm, OpJalr, OpSystem: begin
                top = ins;
                return top >>> 20;
            end
            OpStore: begin
                top = {ins[31:25], ins[11:7], 20'b0};
                return top >>> 20;
            end
            OpBranch: begin
                top = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'b0};
                return top >>> 19;
            end
            OpLui, OpAuipc: return {ins[31:12], 12'h000};
            OpJal: begin
                top = {ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'b0};
                return top >>> 11;
            end
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] readShadow(input logic [4:0] a, input StimEntry e);
        if (a == 5'd0) return '0;
        if (e.wbEnable && e.wbAddr == a) return e.wbData;  // Same-cycle write
        return shadow[a];
    endfunction

    // Drive one entry and advance the model to the state after the next edge
    task automatic applyEntry(input StimEntry e);
        logic bubble;
        bubble     = e.flush || !e.instrValid;
        instr      = e.instr;
        pc         = e.pc;
        instrValid = e.instrValid;
        stall      = e.stall;
        flush      = e.flush;
        wbEnable   = e.wbEnable;
        wbAddr     = e.wbAddr;
        wbData     = e.wbData;
        if (e.flush || !e.stall) begin  // Flush beats stall
            expValid = !bubble;
            expCtrl  = bubble ? 10'b0 : controlFor(e.instr[6:0]);
        end
        if (!e.stall) begin
            expPc       = e.pc;
            expRs1      = readShadow(e.instr[19:15], e);
            expRs2      = readShadow(e.instr[24:20], e);
            expImm      = immFor(e.instr);
            expRd       = e.instr[11:7];
            expFunct3   = e.instr[14:12];
            expFunct7b5 = e.instr[30];
        end
        if (e.wbEnable && e.wbAddr != 5'd0) shadow[e.wbAddr] = e.wbData;
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic checkOutputs();
        checkValue("exValid", 32'(exValid), 32'(expValid));
        checkValue("exALUSrc", 32'(exALUSrc), 32'(expCtrl[9]));
        checkValue("exALUOp", 32'(exALUOp), 32'(expCtrl[8:7]));
        checkValue("exBranch", 32'(exBranch), 32'(expCtrl[6]));
        checkValue("exJump", 32'(exJump), 32'(expCtrl[5]));
        checkValue("exMemRead", 32'(exMemRead), 32'(expCtrl[4]));
        checkValue("exMemWrite", 32'(exMemWrite), 32'(expCtrl[3]));
        checkValue("exMemtoReg", 32'(exMemtoReg), 32'(expCtrl[2]));
        checkValue("exRegWrite", 32'(exRegWrite), 32'(expCtrl[1]));
        checkValue("exIllegal", 32'(exIllegal), 32'(expCtrl[0]));
        if (expValid) begin  // Payload only matters for a real instruction
            checkValue("exPc", exPc, expPc);
            checkValue("exRs1Data", exRs1Data, expRs1);
            checkValue("exRs2Data", exRs2Data, expRs2);
            checkValue("exImm", exImm, expImm);
            checkValue("exRd", 32'(exRd), 32'(expRd));
            checkValue("exFunct3", 32'(exFunct3), 32'(expFunct3));
            checkValue("exFunct7b5", 32'(exFunct7b5), 32'(expFunct7b5));
        end
    endtask

    initial begin
        #1;  // Table is built at time zero
        #((stimTable.size() + ResetCycles + 20) * ClkPeriod);
        $display("Timeout: the decode stage test did not reach its end");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [31:0] data;
        reset_n    = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        wbEnable   = 1'b0;
        wbAddr     = '0;
        wbData     = '0;
        expValid   = 1'b0;
        expCtrl    = '0;
        lfsrState  = 32'hc63ea6b8;
        pcNext     = 32'h0000_1000;
        for (int r = 0; r < NumRegs; r++) begin
            shadow[r] = '0;
        end
        // Preload x1..x7 while fetch sends bubbles
        for (int r = 1; r < 8; r++) begin
            nextRandom(data);
            addEntry(32'h0000_0013, 1'b0, 1'b0, 1'b0, 1'b1, 5'(r), data);
        end
        addEntry(32'h0000_02B3, 1'b1, 1'b0, 1'b0, 1'b1, 5'd0, 32'hDEAD_BEEF);  // add x5,x0,x0
        addEntry(32'hFEDC_B0B7, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // lui, negative
        addEntry(32'h1234_5117, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // auipc
        addEntry(32'hF01F_F0EF, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // jal, backward
        addEntry(32'hFFC3_80E7, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // jalr x1,-4(x7)
        addEntry(32'hFE20_9EE3, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // bne x1,x2
        addEntry(32'hFF81_2183, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // lw x3,-8(x2)
        addEntry(32'hFE31_AE23, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // sw x3,-4(x3)
        addEntry(32'h8003_8393, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // addi x7,x7,-2048
        addEntry(32'h4062_8233, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // sub x4,x5,x6
        addEntry(32'h0FF0_000F, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // fence
        addEntry(32'h0010_0073, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // ebreak
        addEntry(32'h0000_007F, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // Unknown opcode
        nextRandom(data);
        addEntry(32'h0060_8433, 1'b1, 1'b0, 1'b0, 1'b1, 5'd6, data);  // add x8,x1,x6 with bypass
        // Load held by stall while x3 is rewritten behind it
        addEntry(32'hFF81_2183, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        nextRandom(data);
        addEntry(32'h4062_8233, 1'b1, 1'b1, 1'b0, 1'b1, 5'd3, data);
        addEntry(32'h4062_8233, 1'b1, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);
        addEntry(32'h4062_8233, 1'b1, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);
        addEntry(32'h4062_8233, 1'b1, 1'b1, 1'b1, 1'b0, 5'd0, 32'd0);  // Flush under stall
        addEntry(32'hFFC3_80E7, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        addEntry(32'hFFC3_80E7, 1'b1, 1'b0, 1'b1, 1'b0, 5'd0, 32'd0);  // Flush alone
        addEntry(32'hFE31_AE23, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // Fetch bubble
        addEntry(32'hFE31_AE23, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);  // Reads new x3
        addEntry(32'h4062_8233, 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0);  // Stall keeps store

        repeat (ResetCycles) @(posedge clk);
        #1;
        reset_n = 1'b1;
        checkOutputs();  // Reset state before any instruction
        foreach (stimTable[i]) begin
            applyEntry(stimTable[i]);
            @(posedge clk);
            #1;
            checkOutputs();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: ImmGen.sv
// Immediate generator for the decode stage.
// Picks the RV32I immediate format from the opcode, assembles the
// scattered instruction bits and sign-extends to Xlen. Combinational.

module ImmGen (
    input  logic [DecodePkg::Xlen-1:0] instr,
    output logic [DecodePkg::Xlen-1:0] imm
);

    import DecodePkg::*;

    logic [OpcodeWidth-1:0] opcode;
    logic                   sign;

    assign opcode = instr[OpcodeWidth-1:0];
    assign sign   = instr[31];  // Every format takes sign from bit 31

    always_comb begin
        case (opcode)
            OpLoad, OpImm, OpJalr, OpSystem: begin
                imm = {{20{sign}}, instr[31:20]};  // I-type
            end
            OpStore: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};  // S-type
            end
            OpBranch: begin
                // B-type, halfword offset
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OpLui, OpAuipc: begin
                imm = {instr[31:12], 12'b0};  // U-type
            end
            OpJal: begin
                // J-type, halfword offset
                imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // R-type, FENCE, unknown
            end
        endcase
    end

endmodule

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = DecodeStageTb
RTL_TOP   = DecodeStage
FILELIST  = DecodeStage.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: RegFile.sv
// Integer register file for the decode stage.
// Two combinational read ports and one write port from writeback.
// x0 reads zero, a same-cycle write is bypassed to the readers and
// addresses at or above NumRegs read zero (RV32E uses 16 registers).

module RegFile #(
    parameter int NumRegs = 32
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [DecodePkg::RegAddrWidth-1:0] rs1Addr,
    input  logic [DecodePkg::RegAddrWidth-1:0] rs2Addr,
    input  logic [DecodePkg::RegAddrWidth-1:0] wrAddr,
    input  logic                              wrEnable,
    input  logic [DecodePkg::Xlen-1:0]        wrData,
    output logic [DecodePkg::Xlen-1:0]        rs1Data,
    output logic [DecodePkg::Xlen-1:0]        rs2Data
);

    import DecodePkg::*;

    logic [Xlen-1:0] regs [NumRegs];
    logic            wrValid;

    // Writes to x0 or past the array are dropped
    assign wrValid = wrEnable && (wrAddr != '0) && (32'(wrAddr) < NumRegs);

    function automatic logic [Xlen-1:0] readReg(input logic [RegAddrWidth-1:0] addr);
        logic [Xlen-1:0] value;
        value = '0;
        if (addr != '0 && 32'(addr) < NumRegs) begin
            if (wrValid && wrAddr == addr) begin
                value = wrData;  // Write-through bypass
            end else begin
                value = regs[addr];
            end
        end
        return value;
    endfunction

    // Re-evaluated on any change of the array or the write port
    always_comb begin
        rs1Data = readReg(rs1Addr);
        rs2Data = readReg(rs2Addr);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[wrAddr] <= wrData;
        end
    end

    // x0 stays zero even with a bypassed write to it
    assert property (@(posedge clk) disable iff (!reset_n)
        (rs1Addr == '0) |-> (rs1Data == '0));
    assert property (@(posedge clk) disable iff (!reset_n)
        (rs2Addr == '0) |-> (rs2Data == '0));

endmodule
